// File: design/integrityVerifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "oram_config.svh"

module integrityVerifier (
    input  wire                 Clock,
    input  wire                 rstN,

    input  wire oramPkg::beCmdT cmdOutPre,
    input  wire                 cmdOutPreValid,
    output logic                cmdOutPreReady,
    input  wire oramPkg::wordT  storeDataPre,
    input  wire                 storeDataPreValid,
    output logic                storeDataPreReady,
    output oramPkg::wordT       loadDataPre,
    output logic                loadDataPreValid,
    input  wire                 loadDataPreReady,

    output oramPkg::beCmdT      cmdOut,
    output logic                cmdOutValid,
    input  wire                 cmdOutReady,
    output oramPkg::wordT       storeData,
    output logic                storeDataValid,
    input  wire                 storeDataReady,
    input  wire oramPkg::wordT  loadData,
    input  wire                 loadDataValid,
    output logic                loadDataReady,

    output logic                integrityErr
);

    import oramPkg::*;

    localparam int CntW = $clog2(`ORAM_BLOCK_WORDS);

    cmdE                            curCmd;
    addrT                           curAddr;
    logic                           isStore;
    logic                           cmdPreXfer;
    wordT                           laneWord;
    logic                           wordXfer;
    logic [CntW-1:0]                wordCnt;
    logic                           lastWord;
    logic                           blockDone;
    logic [`ORAM_MAC_LANES-1:0][31:0] laneAcc;

    streamReg #(.payloadT(beCmdT)) cmdSlice (
        .Clock   (Clock),
        .rstN    (rstN),
        .inData  (cmdOutPre),
        .inValid (cmdOutPreValid),
        .inReady (cmdOutPreReady),
        .outData (cmdOut),
        .outValid(cmdOutValid),
        .outReady(cmdOutReady)
    );

    // Data words are observed, never delayed
    assign storeData         = storeDataPre;
    assign storeDataValid    = storeDataPreValid;
    assign storeDataPreReady = storeDataReady;
    assign loadDataPre       = loadData;
    assign loadDataPreValid  = loadDataValid;
    assign loadDataReady     = loadDataPreReady;

    assign cmdPreXfer = cmdOutPreValid && cmdOutPreReady;
    assign isStore    = (curCmd == Write) || (curCmd == Append);
    assign laneWord   = isStore ? storeData : loadData;
    assign wordXfer   = isStore ? (storeDataValid && storeDataReady)
                                : (loadDataValid && loadDataReady);
    assign lastWord   = (wordCnt == CntW'(`ORAM_BLOCK_WORDS - 1));

    // Block in progress and its word position
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            curCmd    <= Read;
            curAddr   <= '0;
            wordCnt   <= '0;
            blockDone <= 1'b0;
        end else begin
            blockDone <= wordXfer && lastWord;
            if (cmdPreXfer) begin
                curCmd  <= cmdOutPre.cmd;
                curAddr <= cmdOutPre.addr;
                wordCnt <= '0;
            end else if (wordXfer) begin
                wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
            end
        end
    end

    // Word i goes to lane i mod lane count
    for (genvar g = 0; g < `ORAM_MAC_LANES; g++) begin : genLane
        logic [31:0] laneKey;
        logic        laneValid;

        assign laneKey   = `ORAM_MAC_KEY + 32'(g) * `ORAM_MAC_KEY_STEP;
        assign laneValid = wordXfer && ((int'(wordCnt) % `ORAM_MAC_LANES) == g);

        macLane lane (
            .Clock    (Clock),
            .rstN     (rstN),
            .start    (cmdPreXfer),
            .word     (laneWord),
            .wordValid(laneValid),
            .laneKey  (laneKey),
            .acc      (laneAcc[g])
        );
    end

    tagCheck check (
        .Clock       (Clock),
        .rstN        (rstN),
        .laneAcc     (laneAcc),
        .blockDone   (blockDone),
        .blockAddr   (curAddr),
        .blockIsStore(isStore),
        .integrityErr(integrityErr)
    );

endmodule

`default_nettype wire

// File: design/macLane.sv
`timescale 1ns/1ps
`default_nettype none

// One keyed mixing lane of the block MAC
module macLane (
    input  wire                Clock,
    input  wire                rstN,
    input  wire                start,
    input  wire oramPkg::wordT word,
    input  wire                wordValid,
    input  wire [31:0]         laneKey,
    output logic [31:0]        acc
);

    logic [31:0] mixed;
    logic [31:0] rotated;

    assign mixed   = 32'(word) + laneKey;
    assign rotated = {acc[26:0], acc[31:27]};

    // Start wins over a word in the same cycle
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (start) begin
            acc <= '0;
        end else if (wordValid) begin
            acc <= rotated ^ mixed;
        end
    end

endmodule

`default_nettype wire

// File: design/oramFrontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "oram_config.svh"

module oramFrontend (
    input  wire                 Clock,
    input  wire                 rstN,

    // Network side
    input  wire oramPkg::feCmdT cmdIn,
    input  wire                 cmdInValid,
    output logic                cmdInReady,
    input  wire oramPkg::wordT  dataIn,
    input  wire                 dataInValid,
    output logic                dataInReady,
    output oramPkg::wordT       returnData,
    output logic                returnDataValid,
    input  wire                 returnDataReady,

    // Backend side
    output oramPkg::beCmdT      cmdOut,
    output logic                cmdOutValid,
    input  wire                 cmdOutReady,
    output oramPkg::wordT       storeData,
    output logic                storeDataValid,
    input  wire                 storeDataReady,
    input  wire oramPkg::wordT  loadData,
    input  wire                 loadDataValid,
    output logic                loadDataReady,

    output logic                integrityErr
);

    import oramPkg::*;

    beCmdT cmdOutPre;
    logic  cmdOutPreValid;
    logic  cmdOutPreReady;
    wordT  storeDataPre;
    logic  storeDataPreValid;
    logic  storeDataPreReady;
    wordT  loadDataPre;
    logic  loadDataPreValid;
    logic  loadDataPreReady;

    posMapController pmc (
        .Clock          (Clock),
        .rstN           (rstN),
        .cmdIn          (cmdIn),
        .cmdInValid     (cmdInValid),
        .cmdInReady     (cmdInReady),
        .dataIn         (dataIn),
        .dataInValid    (dataInValid),
        .dataInReady    (dataInReady),
        .returnData     (returnData),
        .returnDataValid(returnDataValid),
        .returnDataReady(returnDataReady),
        .cmdOut         (cmdOutPre),
        .cmdOutValid    (cmdOutPreValid),
        .cmdOutReady    (cmdOutPreReady),
        .storeData      (storeDataPre),
        .storeDataValid (storeDataPreValid),
        .storeDataReady (storeDataPreReady),
        .loadData       (loadDataPre),
        .loadDataValid  (loadDataPreValid),
        .loadDataReady  (loadDataPreReady)
    );

    // ====================
    // Optional integrity stage
    // ====================

    if (`ORAM_ENABLE_IV == 1) begin : genIv
        integrityVerifier iv (
            .Clock            (Clock),
            .rstN             (rstN),
            .cmdOutPre        (cmdOutPre),
            .cmdOutPreValid   (cmdOutPreValid),
            .cmdOutPreReady   (cmdOutPreReady),
            .storeDataPre     (storeDataPre),
            .storeDataPreValid(storeDataPreValid),
            .storeDataPreReady(storeDataPreReady),
            .loadDataPre      (loadDataPre),
            .loadDataPreValid (loadDataPreValid),
            .loadDataPreReady (loadDataPreReady),
            .cmdOut           (cmdOut),
            .cmdOutValid      (cmdOutValid),
            .cmdOutReady      (cmdOutReady),
            .storeData        (storeData),
            .storeDataValid   (storeDataValid),
            .storeDataReady   (storeDataReady),
            .loadData         (loadData),
            .loadDataValid    (loadDataValid),
            .loadDataReady    (loadDataReady),
            .integrityErr     (integrityErr)
        );
    end else begin : genNoIv
        // Backend sees the controller directly
        assign cmdOut            = cmdOutPre;
        assign cmdOutValid       = cmdOutPreValid;
        assign cmdOutPreReady    = cmdOutReady;
        assign storeData         = storeDataPre;
        assign storeDataValid    = storeDataPreValid;
        assign storeDataPreReady = storeDataReady;
        assign loadDataPre       = loadData;
        assign loadDataPreValid  = loadDataValid;
        assign loadDataReady     = loadDataPreReady;
        assign integrityErr      = 1'b0;
    end

endmodule

`default_nettype wire

// File: design/oramPkg.sv
`default_nettype none

`include "oram_config.svh"

package oramPkg;

    // Block commands shared by network and backend
    typedef enum logic [1:0] {
        Read    = 2'd0,
        Write   = 2'd1,
        Append  = 2'd2,
        ReadRmv = 2'd3
    } cmdE;

    typedef logic [`ORAM_U-1:0]   addrT;
    typedef logic [`ORAM_L-1:0]   leafT;
    typedef logic [`ORAM_FED-1:0] wordT;

    // Command as issued by the network
    typedef struct packed {
        cmdE  cmd;
        addrT addr;
    } feCmdT;

    // Command as sent to the backend, with the remap pair
    typedef struct packed {
        cmdE  cmd;
        addrT addr;
        leafT oldLeaf;
        leafT newLeaf;
    } beCmdT;

endpackage

`default_nettype wire

// File: design/oram_config.svh
`ifndef ORAM_CONFIG_SVH
`define ORAM_CONFIG_SVH

// ====================
// Frontend geometry
// ====================

// Program address and leaf widths
`define ORAM_U 6
`define ORAM_L 5

// Data word width and words per block
`define ORAM_FED 32
`define ORAM_BLOCK_WORDS 4

// ====================
// Integrity verifier
// ====================

// Block word count must be a multiple of the lane count
`define ORAM_MAC_LANES 2
`define ORAM_MAC_KEY 32'h5A17C3E9
// Lane n key is base key plus n times this step
`define ORAM_MAC_KEY_STEP 32'h9E3779B9
`define ORAM_ENABLE_IV 1

`endif

// File: design/posMapController.sv
`timescale 1ns/1ps
`default_nettype none

`include "oram_config.svh"

module posMapController (
    input  wire             Clock,
    input  wire             rstN,

    input  wire oramPkg::feCmdT cmdIn,
    input  wire             cmdInValid,
    output logic            cmdInReady,

    input  wire oramPkg::wordT dataIn,
    input  wire             dataInValid,
    output logic            dataInReady,

    output oramPkg::wordT   returnData,
    output logic            returnDataValid,
    input  wire             returnDataReady,

    output oramPkg::beCmdT  cmdOut,
    output logic            cmdOutValid,
    input  wire             cmdOutReady,

    output oramPkg::wordT   storeData,
    output logic            storeDataValid,
    input  wire             storeDataReady,

    input  wire oramPkg::wordT loadData,
    input  wire             loadDataValid,
    output logic            loadDataReady
);

    import oramPkg::*;

    localparam int CntW = $clog2(`ORAM_BLOCK_WORDS);

    typedef enum logic [1:0] {
        phaseIdle,
        phaseCmd,
        phaseWrite,
        phaseRead
    } phaseE;

    phaseE           phase;
    cmdE             curCmd;
    logic [CntW-1:0] wordCnt;
    logic            outOfReset;
    logic [15:0]     lfsr;

    // Position map, one leaf per program address
    leafT                  leafTable [2**`ORAM_U];
    logic [2**`ORAM_U-1:0] leafValid;

    beCmdT nextCmd;
    logic  sliceReady;
    logic  cmdAccept;
    logic  wordXfer;
    logic  lastWord;

    // ====================
    // Command path
    // ====================

    assign cmdInReady = outOfReset && (phase == phaseIdle) && sliceReady;
    assign cmdAccept  = cmdInValid && cmdInReady;

    // Unmapped blocks report leaf 0
    always_comb begin
        nextCmd.cmd     = cmdIn.cmd;
        nextCmd.addr    = cmdIn.addr;
        nextCmd.oldLeaf = leafValid[cmdIn.addr] ? leafTable[cmdIn.addr] : '0;
        nextCmd.newLeaf = lfsr[`ORAM_L-1:0];
    end

    streamReg #(.payloadT(beCmdT)) cmdSlice (
        .Clock   (Clock),
        .rstN    (rstN),
        .inData  (nextCmd),
        .inValid (cmdAccept),
        .inReady (sliceReady),
        .outData (cmdOut),
        .outValid(cmdOutValid),
        .outReady(cmdOutReady)
    );

    always_ff @(posedge Clock) begin
        if (cmdAccept && (cmdIn.cmd != ReadRmv)) begin
            leafTable[cmdIn.addr] <= nextCmd.newLeaf;
        end
    end

    // ====================
    // Data path
    // ====================

    assign storeData       = dataIn;
    assign storeDataValid  = (phase == phaseWrite) && dataInValid;
    assign dataInReady     = (phase == phaseWrite) && storeDataReady;

    assign returnData      = loadData;
    assign returnDataValid = (phase == phaseRead) && loadDataValid;
    assign loadDataReady   = (phase == phaseRead) && returnDataReady;

    assign wordXfer = (storeDataValid && storeDataReady) ||
                      (returnDataValid && returnDataReady);
    assign lastWord = (wordCnt == CntW'(`ORAM_BLOCK_WORDS - 1));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            phase      <= phaseIdle;
            curCmd     <= Read;
            wordCnt    <= '0;
            outOfReset <= 1'b0;
            lfsr       <= 16'hACE1;
            leafValid  <= '0;
        end else begin
            outOfReset <= 1'b1;
            // Taps 16, 14, 13, 11
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            case (phase)
                phaseIdle: begin
                    if (cmdAccept) begin
                        phase  <= phaseCmd;
                        curCmd <= cmdIn.cmd;
                        leafValid[cmdIn.addr] <= (cmdIn.cmd != ReadRmv);
                    end
                end
                phaseCmd: begin
                    if (cmdOutValid && cmdOutReady) begin
                        phase <= ((curCmd == Write) || (curCmd == Append)) ?
                                 phaseWrite : phaseRead;
                    end
                end
                default: begin
                    if (wordXfer) begin
                        wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
                        if (lastWord) begin
                            phase <= phaseIdle;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/streamReg.sv
`timescale 1ns/1ps
`default_nettype none

// One-entry ready/valid register slice
module streamReg #(
    parameter type payloadT = logic
) (
    input  wire          Clock,
    input  wire          rstN,

    input  wire payloadT inData,
    input  wire          inValid,
    output logic         inReady,

    output payloadT      outData,
    output logic         outValid,
    input  wire          outReady
);

    logic loadEntry;

    // Empty, or the held entry leaves this cycle
    assign inReady   = !outValid || outReady;
    assign loadEntry = inValid && inReady;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (loadEntry) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // Payload only moves with a new entry
    always_ff @(posedge Clock) begin
        if (loadEntry) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: design/tagCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "oram_config.svh"

module tagCheck (
    input  wire                               Clock,
    input  wire                               rstN,
    input  wire [`ORAM_MAC_LANES-1:0][31:0]   laneAcc,
    input  wire                               blockDone,
    input  wire oramPkg::addrT                blockAddr,
    input  wire                               blockIsStore,
    output logic                              integrityErr
);

    logic [31:0] tag;
    logic        mismatch;

    // One reference tag per program address
    logic [31:0]           tagMem [2**`ORAM_U];
    logic [2**`ORAM_U-1:0] seen;

    // ====================
    // Tag of the finished block
    // ====================

    always_comb begin
        tag = '0;
        for (int i = 0; i < `ORAM_MAC_LANES; i++) begin
            tag ^= laneAcc[i];
        end
    end

    always_ff @(posedge Clock) begin
        if (blockDone && blockIsStore) begin
            tagMem[blockAddr] <= tag;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            seen <= '0;
        end else if (blockDone && blockIsStore) begin
            seen[blockAddr] <= 1'b1;
        end
    end

    // ====================
    // Load check
    // ====================

    // Addresses never stored have nothing to compare against
    assign mismatch     = seen[blockAddr] && (tagMem[blockAddr] != tag);
    assign integrityErr = blockDone && !blockIsStore && mismatch;

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/oramPkg.sv
design/streamReg.sv
design/macLane.sv
design/tagCheck.sv
design/integrityVerifier.sv
design/posMapController.sv
design/oramFrontend.sv
tests/oramFrontend_properties.sv
tests/oramFrontendTb.sv

// File: tests/oramFrontendTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "oram_config.svh"

module oramFrontendTb;

    import oramPkg::*;

    localparam int Words       = `ORAM_BLOCK_WORDS;
    localparam int Lanes       = `ORAM_MAC_LANES;
    localparam int Depth       = 2**`ORAM_U;
    localparam int ResetCycles = 10;
    localparam int NumCmds     = 78;
    localparam logic [31:0] FlipMask = 32'h0000_0200;

    typedef logic [Words-1:0][`ORAM_FED-1:0] blockT;

    logic   Clock;
    logic   rstN;
    feCmdT  cmdIn;
    logic   cmdInValid;
    logic   cmdInReady;
    wordT   dataIn;
    logic   dataInValid;
    logic   dataInReady;
    wordT   returnData;
    logic   returnDataValid;
    logic   returnDataReady;
    beCmdT  cmdOut;
    logic   cmdOutValid;
    logic   cmdOutReady;
    wordT   storeData;
    logic   storeDataValid;
    logic   storeDataReady;
    wordT   loadData;
    logic   loadDataValid;
    logic   loadDataReady;
    logic   integrityErr;

    int     seed = 62;
    int     errors = 0;
    int     checks = 0;
    int     testErrStart = 0;
    bit     stallOn = 1'b0;
    logic   errDue = 1'b0;
    int     retCnt = 0;

    // Expected events, in issue order
    feCmdT  expCmdQ [$];
    wordT   expWordQ [$];
    logic   expErrQ [$];
    logic   corruptQ [$];

    // Reference state and backend memory
    blockT        refMem [Depth];
    blockT        beMem [Depth];
    logic [31:0]  refTag [Depth];
    logic         refSeen [Depth];
    leafT         lastLeaf [Depth];
    logic         mapValid [Depth];

    oramFrontend uut (.*);

    always #2 Clock = ~Clock;

    // ====================
    // Reference functions
    // ====================

    // Content of a block never stored
    function automatic blockT fillBlock(input addrT a);
        blockT b;
        for (int i = 0; i < Words; i++) begin
            b[i] = {8'hA5, 2'b00, a, 12'h3C0, 4'(i)};
        end
        return b;
    endfunction

    function automatic blockT randomBlock();
        blockT b;
        for (int i = 0; i < Words; i++) begin
            b[i] = $random(seed);
        end
        return b;
    endfunction

    // Keyed lane fold, lanes XORed into one tag
    function automatic logic [31:0] blockTag(input blockT b);
        logic [31:0] acc [Lanes];
        logic [31:0] key;
        logic [31:0] tag;
        int          lane;
        for (int n = 0; n < Lanes; n++) begin
            acc[n] = '0;
        end
        for (int i = 0; i < Words; i++) begin
            lane = i % Lanes;
            key = `ORAM_MAC_KEY + 32'(lane) * `ORAM_MAC_KEY_STEP;
            acc[lane] = {acc[lane][26:0], acc[lane][31:27]} ^ (b[i] + key);
        end
        tag = '0;
        for (int n = 0; n < Lanes; n++) begin
            tag ^= acc[n];
        end
        return tag;
    endfunction

    function automatic logic readyDraw();
        return stallOn ? (($random(seed) & 3) != 0) : 1'b1;
    endfunction

    // ====================
    // Network driver
    // ====================

    task automatic sendCmd(input cmdE c, input addrT a);
        feCmdT fc;
        fc.cmd = c;
        fc.addr = a;
        expCmdQ.push_back(fc);
        cmdIn = fc;
        cmdInValid = 1'b1;
        do @(posedge Clock); while (!cmdInReady);
        #1;
        cmdInValid = 1'b0;
    endtask

    task automatic storeBlock(input cmdE c, input addrT a, input blockT b);
        refMem[a] = b;
        refTag[a] = blockTag(b);
        refSeen[a] = 1'b1;
        sendCmd(c, a);
        for (int i = 0; i < Words; i++) begin
            while (stallOn && ($random(seed) & 1)) begin
                @(posedge Clock);
                #1;
            end
            dataIn = b[i];
            dataInValid = 1'b1;
            do @(posedge Clock); while (!dataInReady);
            #1;
            dataInValid = 1'b0;
        end
    endtask

    task automatic loadBlock(input cmdE c, input addrT a, input logic corrupt);
        blockT b;
        b = refMem[a];
        if (corrupt) begin
            b[2] = b[2] ^ FlipMask;
        end
        for (int i = 0; i < Words; i++) begin
            expWordQ.push_back(b[i]);
        end
        expErrQ.push_back(refSeen[a] && (refTag[a] != blockTag(b)));
        corruptQ.push_back(corrupt);
        sendCmd(c, a);
    endtask

    task automatic endTest(input string name);
        while (expCmdQ.size() != 0 || expWordQ.size() != 0 || expErrQ.size() != 0 || errDue) begin
            @(posedge Clock);
        end
        repeat (2) @(posedge Clock);
        #1;
        $display("test %-18s %s (%0d errors)", name,
                 (errors == testErrStart) ? "ok" : "failed", errors - testErrStart);
        testErrStart = errors;
    endtask

    always begin
        @(posedge Clock);
        #1;
        returnDataReady = rstN && readyDraw();
    end

    // ====================
    // Backend model
    // ====================

    initial begin : backendModel
        beCmdT bc;
        logic  flip;
        int    i;
        cmdOutReady = 1'b0;
        storeDataReady = 1'b0;
        loadData = '0;
        loadDataValid = 1'b0;
        for (int a = 0; a < Depth; a++) begin
            beMem[a] = fillBlock(addrT'(a));
        end
        wait (rstN === 1'b1);
        @(posedge Clock);
        #1;
        forever begin
            cmdOutReady = readyDraw();
            @(posedge Clock);
            if (cmdOutValid && cmdOutReady) begin
                bc = cmdOut;
                #1;
                cmdOutReady = 1'b0;
                if (bc.cmd == Write || bc.cmd == Append) begin
                    i = 0;
                    while (i < Words) begin
                        storeDataReady = readyDraw();
                        @(posedge Clock);
                        if (storeDataValid && storeDataReady) begin
                            beMem[bc.addr][i] = storeData;
                            i++;
                        end
                        #1;
                    end
                    storeDataReady = 1'b0;
                end else begin
                    flip = (corruptQ.size() != 0) ? corruptQ.pop_front() : 1'b0;
                    for (i = 0; i < Words; i++) begin
                        // One flipped bit in word 2 when asked
                        loadData = beMem[bc.addr][i] ^ ((flip && i == 2) ? FlipMask : '0);
                        loadDataValid = 1'b1;
                        do @(posedge Clock); while (!loadDataReady);
                        #1;
                    end
                    loadDataValid = 1'b0;
                end
            end else begin
                #1;
            end
        end
    end

    // ====================
    // Comparing process
    // ====================

    always @(posedge Clock) begin : compare
        feCmdT ec;
        wordT  ew;
        logic  ee;
        leafT  expOld;
        if (rstN) begin
            checks++;
            if (errDue) begin
                ee = (expErrQ.size() != 0) ? expErrQ.pop_front() : 1'b0;
                errDue = 1'b0;
                assert (integrityErr === ee) else begin
                    errors++;
                    $display("ERR %0t: integrityErr %b, expected %b", $time, integrityErr, ee);
                end
            end else begin
                assert (integrityErr === 1'b0) else begin
                    errors++;
                    $display("ERR %0t: integrityErr pulsed outside a load check", $time);
                end
            end
            if (cmdOutValid && cmdOutReady) begin
                if (expCmdQ.size() == 0) begin
                    errors++;
                    $display("A backend command appeared at %0t with none outstanding", $time);
                end else begin
                    ec = expCmdQ.pop_front();
                    expOld = mapValid[ec.addr] ? lastLeaf[ec.addr] : '0;
                    checks++;
                    assert (cmdOut.cmd === ec.cmd && cmdOut.addr === ec.addr &&
                            cmdOut.oldLeaf === expOld) else begin
                        errors++;
                        $display("ERR %0t: cmdOut %s/%0d/old %0d, expected %s/%0d/old %0d",
                                 $time, cmdOut.cmd.name(), cmdOut.addr, cmdOut.oldLeaf,
                                 ec.cmd.name(), ec.addr, expOld);
                    end
                    lastLeaf[ec.addr] = cmdOut.newLeaf;
                    mapValid[ec.addr] = (ec.cmd != ReadRmv);
                end
            end
            if (returnDataValid && returnDataReady) begin
                if (expWordQ.size() == 0) begin
                    errors++;
                    $display("A return word arrived at %0t that no read asked for", $time);
                end else begin
                    ew = expWordQ.pop_front();
                    checks++;
                    assert (returnData === ew) else begin
                        errors++;
                        $display("ERR %0t: returnData %h, expected %h", $time, returnData, ew);
                    end
                end
                retCnt++;
                // Flag is due the cycle after the last word
                if (retCnt == Words) begin
                    retCnt = 0;
                    errDue = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (ResetCycles + 200 * NumCmds) @(posedge Clock);
        $display("Timeout: the commands did not all complete in time");
        $display("Done: errors found");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial begin : mainSeq
        Clock = 1'b0;
        rstN = 1'b0;
        cmdIn = '0;
        cmdInValid = 1'b0;
        dataIn = '0;
        dataInValid = 1'b0;
        returnDataReady = 1'b0;
        for (int a = 0; a < Depth; a++) begin
            refMem[a] = fillBlock(addrT'(a));
            refSeen[a] = 1'b0;
            mapValid[a] = 1'b0;
        end
        repeat (ResetCycles) @(posedge Clock);
        #1;
        rstN = 1'b1;

        for (int a = 0; a < 16; a++) storeBlock(Append, addrT'(a), randomBlock());
        for (int a = 0; a < 16; a++) loadBlock(Read, addrT'(a), 1'b0);
        endTest("append/read");

        // Old leaf follows the previous new leaf, and drops to 0 after ReadRmv
        for (int a = 20; a < 24; a++) begin
            storeBlock(Write, addrT'(a), randomBlock());
            loadBlock(Read, addrT'(a), 1'b0);
            loadBlock(ReadRmv, addrT'(a), 1'b0);
            loadBlock(Read, addrT'(a), 1'b0);
        end
        endTest("leaf chaining");

        stallOn = 1'b1;
        for (int a = 32; a < 40; a++) storeBlock(Append, addrT'(a), randomBlock());
        for (int a = 32; a < 40; a++) loadBlock(Read, addrT'(a), 1'b0);
        endTest("back-pressure");

        for (int a = 0; a < 8; a++) loadBlock(Read, addrT'(a), 1'b0);
        endTest("integrity pass");

        loadBlock(Read, addrT'(3), 1'b1);
        loadBlock(Read, addrT'(34), 1'b1);
        endTest("integrity failure");

        for (int a = 48; a < 52; a++) loadBlock(Read, addrT'(a), 1'b0);
        endTest("unwritten reads");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/oramFrontend_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake rules on the top-level ports
module oramFrontendProperties (
    input wire                 Clock,
    input wire                 rstN,
    input wire oramPkg::beCmdT cmdOut,
    input wire                 cmdOutValid,
    input wire                 cmdOutReady,
    input wire oramPkg::wordT  storeData,
    input wire                 storeDataValid,
    input wire                 storeDataReady,
    input wire oramPkg::wordT  returnData,
    input wire                 returnDataValid,
    input wire                 returnDataReady,
    input wire                 integrityErr
);

    // A valid stays up with a steady payload until it transfers
    cmdOutHeld: assert property (@(posedge Clock) disable iff (!rstN)
        cmdOutValid && !cmdOutReady |=> cmdOutValid && $stable(cmdOut))
        else $error("cmdOut dropped or changed before its transfer");

    storeHeld: assert property (@(posedge Clock) disable iff (!rstN)
        storeDataValid && !storeDataReady |=> storeDataValid && $stable(storeData))
        else $error("storeData dropped or changed before its transfer");

    returnHeld: assert property (@(posedge Clock) disable iff (!rstN)
        returnDataValid && !returnDataReady |=> returnDataValid && $stable(returnData))
        else $error("returnData dropped or changed before its transfer");

    // Single-cycle flag
    errPulse: assert property (@(posedge Clock) disable iff (!rstN)
        integrityErr |=> !integrityErr)
        else $error("integrityErr held for more than one cycle");

endmodule

bind oramFrontend oramFrontendProperties props (
    .Clock          (Clock),
    .rstN           (rstN),
    .cmdOut         (cmdOut),
    .cmdOutValid    (cmdOutValid),
    .cmdOutReady    (cmdOutReady),
    .storeData      (storeData),
    .storeDataValid (storeDataValid),
    .storeDataReady (storeDataReady),
    .returnData     (returnData),
    .returnDataValid(returnDataValid),
    .returnDataReady(returnDataReady),
    .integrityErr   (integrityErr)
);

`default_nettype wire
